// ==== common/host_bridge_pkg.sv ====
package host_bridge_pkg;

	// ------------------------------------------------------------------------
	// data path widths
	// ------------------------------------------------------------------------
	localparam int WORD_W = 32;                  // host pipe word
	typedef logic [WORD_W-1:0] word_t;

	localparam int COUNT_W = 10;                 // holds 0..FIFO_DEPTH
	typedef logic [COUNT_W-1:0] count_t;

	// ------------------------------------------------------------------------
	// pipe FIFOs and block throttle
	// ------------------------------------------------------------------------
	localparam int FIFO_DEPTH      = 1023;       // one short of a power of two
	localparam int BLOCK_SIZE      = 128;        // 512 byte host block
	localparam int BUFFER_HEADROOM = 20;         // slack for late count updates

	// room for one more block after the count settles
	localparam count_t PIPE_IN_LIMIT  = count_t'(FIFO_DEPTH - BUFFER_HEADROOM - BLOCK_SIZE);
	localparam count_t PIPE_OUT_SPACE = count_t'(FIFO_DEPTH - BUFFER_HEADROOM - BLOCK_SIZE);

	// ------------------------------------------------------------------------
	// word store
	// ------------------------------------------------------------------------
	localparam int MEM_AW = 10;                  // 1024 words
	typedef logic [MEM_AW-1:0] addr_t;

	localparam int CALIB_CYCLES = 8;             // power-up delay before use
	localparam int CALIB_W      = $clog2(CALIB_CYCLES + 1);

	// control wire bit positions
	localparam int CTRL_PIPE_READ  = 0;          // store to pipe-out
	localparam int CTRL_PIPE_WRITE = 1;          // pipe-in to store
	localparam int CTRL_FLUSH      = 2;          // clears FIFOs and DMA

endpackage

// ==== src/word_fifo.sv ====
`timescale 1ns/1ns

module word_fifo (
	input  logic                   okClk,
	input  logic                   i_reset,
	input  logic                   i_write,
	input  host_bridge_pkg::word_t i_wdata,
	input  logic                   i_read,
	output host_bridge_pkg::word_t o_rdata,
	output logic                   o_rvalid,
	output host_bridge_pkg::count_t o_count,
	output logic                   o_full,
	output logic                   o_empty
);
	import host_bridge_pkg::*;

	word_t  mem [FIFO_DEPTH];
	count_t wr_ptr;
	count_t rd_ptr;
	logic   wr_ok;
	logic   rd_ok;

	// pointers wrap at the depth, which is not a power of two
	function automatic count_t next_ptr(input count_t ptr);
		count_t nxt;
		if (ptr == count_t'(FIFO_DEPTH - 1)) begin
			nxt = '0;
		end else begin
			nxt = ptr + 1'b1;
		end
		return nxt;
	endfunction

	assign o_full  = (o_count == count_t'(FIFO_DEPTH));
	assign o_empty = (o_count == '0);
	assign wr_ok   = i_write && !o_full;              // write into full is dropped
	assign rd_ok   = i_read && !o_empty;              // read from empty is dropped

	always_ff @(posedge okClk) begin
		if (i_reset) begin
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			o_count  <= '0;
			o_rvalid <= 1'b0;
		end else begin
			o_rvalid <= rd_ok;
			if (wr_ok) begin
				wr_ptr <= next_ptr(wr_ptr);
			end
			if (rd_ok) begin
				rd_ptr <= next_ptr(rd_ptr);
			end
			case ({wr_ok, rd_ok})
				2'b10:   o_count <= o_count + 1'b1;
				2'b01:   o_count <= o_count - 1'b1;
				default: o_count <= o_count;          // both or neither
			endcase
		end
	end

	// storage and read register
	always_ff @(posedge okClk) begin
		if (wr_ok) begin
			mem[wr_ptr] <= i_wdata;
		end
		if (rd_ok) begin
			o_rdata <= mem[rd_ptr];                   // valid with o_rvalid
		end
	end

endmodule

// ==== pipe/pipe_endpoints.sv ====
`timescale 1ns/1ns

module pipe_endpoints (
	input  logic                    okClk,
	input  logic                    i_reset,
	input  logic                    i_flush,
	// host pipe-in side
	input  logic                    i_pi_write,
	input  host_bridge_pkg::word_t  i_pi_data,
	output logic                    o_pi_ready,
	// host pipe-out side
	input  logic                    i_po_read,
	output host_bridge_pkg::word_t  o_po_data,
	// DMA side of pipe-in
	input  logic                    i_dma_pi_read,
	output host_bridge_pkg::word_t  o_dma_pi_data,
	output logic                    o_dma_pi_valid,
	output host_bridge_pkg::count_t o_pi_count,
	// DMA side of pipe-out
	input  logic                    i_dma_po_write,
	input  host_bridge_pkg::word_t  i_dma_po_data,
	output host_bridge_pkg::count_t o_po_count,
	output logic                    o_po_ready,
	// status for the LED view
	output logic                    o_pi_full,
	output logic                    o_pi_empty,
	output logic                    o_po_full,
	output logic                    o_po_empty
);
	import host_bridge_pkg::*;

	logic fifo_reset;

	assign fifo_reset = i_reset | i_flush;            // flush empties both pipes

	// ------------------------------------------------------------------------
	// pipe FIFOs
	// ------------------------------------------------------------------------
	word_fifo pipe_in_fifo (
		.okClk    (okClk),
		.i_reset  (fifo_reset),
		.i_write  (i_pi_write),                   // host strobe
		.i_wdata  (i_pi_data),
		.i_read   (i_dma_pi_read),                // DMA strobe
		.o_rdata  (o_dma_pi_data),
		.o_rvalid (o_dma_pi_valid),
		.o_count  (o_pi_count),
		.o_full   (o_pi_full),
		.o_empty  (o_pi_empty)
	);

	word_fifo pipe_out_fifo (
		.okClk    (okClk),
		.i_reset  (fifo_reset),
		.i_write  (i_dma_po_write),               // DMA strobe
		.i_wdata  (i_dma_po_data),
		.i_read   (i_po_read),                    // host strobe
		.o_rdata  (o_po_data),
		.o_rvalid (),                             // host times the word itself
		.o_count  (o_po_count),
		.o_full   (o_po_full),
		.o_empty  (o_po_empty)
	);

	// ------------------------------------------------------------------------
	// block throttle
	// ------------------------------------------------------------------------
	always_ff @(posedge okClk) begin
		if (fifo_reset) begin
			o_pi_ready <= 1'b1;                       // empty pipe-in takes a block
			o_po_ready <= 1'b0;
		end else begin
			o_pi_ready <= (o_pi_count <= PIPE_IN_LIMIT);
			o_po_ready <= (o_po_count >= count_t'(BLOCK_SIZE));
		end
	end

endmodule

// ==== dma/block_dma.sv ====
`timescale 1ns/1ns

module block_dma (
	input  logic                    okClk,
	input  logic                    i_reset,
	input  host_bridge_pkg::word_t  i_ctrl,
	input  host_bridge_pkg::addr_t  i_start_addr,
	input  logic                    i_calib_done,
	// pipe-in FIFO
	output logic                    o_pi_read,
	input  host_bridge_pkg::word_t  i_pi_data,
	input  logic                    i_pi_valid,
	input  host_bridge_pkg::count_t i_pi_count,
	// pipe-out FIFO
	output logic                    o_po_write,
	output host_bridge_pkg::word_t  o_po_data,
	input  host_bridge_pkg::count_t i_po_count,
	// word store
	output logic                    o_mem_we,
	output host_bridge_pkg::addr_t  o_mem_waddr,
	output host_bridge_pkg::word_t  o_mem_wdata,
	output logic                    o_mem_re,
	output host_bridge_pkg::addr_t  o_mem_raddr,
	input  host_bridge_pkg::word_t  i_mem_rdata,
	output logic                    o_busy
);
	import host_bridge_pkg::*;

	typedef enum logic [1:0] {
		S_IDLE,
		S_WRITE,
		S_READ
	} state_t;

	state_t state;
	logic   flush;
	logic   dma_reset;
	logic   wr_bit;
	logic   rd_bit;
	logic   wr_bit_q;
	logic   rd_bit_q;
	logic   start_write;
	logic   start_read;
	logic   issue_open;
	logic   mem_rvalid;
	addr_t  wr_ptr;
	addr_t  rd_ptr;
	count_t issue_cnt;                                // strobes sent in this burst
	count_t done_cnt;                                 // words landed in this burst

	assign flush     = i_ctrl[CTRL_FLUSH];
	assign wr_bit    = i_ctrl[CTRL_PIPE_WRITE];
	assign rd_bit    = i_ctrl[CTRL_PIPE_READ];
	assign dma_reset = i_reset | flush;

	// the registered bit delays a start until the pointer has loaded
	assign start_write = wr_bit && wr_bit_q && i_calib_done
		&& (i_pi_count >= count_t'(BLOCK_SIZE));
	assign start_read  = rd_bit && rd_bit_q && i_calib_done
		&& (i_po_count <= PIPE_OUT_SPACE);

	assign issue_open  = (issue_cnt != count_t'(BLOCK_SIZE));
	assign o_pi_read   = (state == S_WRITE) && issue_open;
	assign o_mem_re    = (state == S_READ) && issue_open;
	assign o_mem_we    = (state == S_WRITE) && i_pi_valid;  // FIFO word lands directly
	assign o_mem_waddr = wr_ptr;
	assign o_mem_wdata = i_pi_data;
	assign o_mem_raddr = rd_ptr;
	assign o_busy      = (state != S_IDLE);

	// ------------------------------------------------------------------------
	// address pointers, loaded on a rising enable bit
	// ------------------------------------------------------------------------
	always_ff @(posedge okClk) begin
		if (i_reset) begin
			wr_bit_q <= 1'b0;
			rd_bit_q <= 1'b0;
			wr_ptr   <= '0;
			rd_ptr   <= '0;
		end else begin
			wr_bit_q <= wr_bit;
			rd_bit_q <= rd_bit;
			if (wr_bit && !wr_bit_q) begin
				wr_ptr <= i_start_addr;
			end else if (o_mem_we) begin
				wr_ptr <= wr_ptr + 1'b1;              // wraps at the store size
			end
			if (rd_bit && !rd_bit_q) begin
				rd_ptr <= i_start_addr;
			end else if (o_mem_re) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

	// ------------------------------------------------------------------------
	// burst FSM
	// ------------------------------------------------------------------------
	always_ff @(posedge okClk) begin
		if (dma_reset) begin
			state     <= S_IDLE;
			issue_cnt <= '0;
			done_cnt  <= '0;
		end else begin
			if (o_pi_read || o_mem_re) begin
				issue_cnt <= issue_cnt + 1'b1;
			end
			case (state)
				S_IDLE: begin
					issue_cnt <= '0;
					done_cnt  <= '0;
					if (start_write) begin
						state <= S_WRITE;             // write side wins a tie
					end else if (start_read) begin
						state <= S_READ;
					end
				end
				S_WRITE: begin
					if (o_mem_we) begin
						done_cnt <= done_cnt + 1'b1;
						if (done_cnt == count_t'(BLOCK_SIZE - 1)) begin
							state <= S_IDLE;
						end
					end
				end
				S_READ: begin
					if (o_po_write) begin
						done_cnt <= done_cnt + 1'b1;
						if (done_cnt == count_t'(BLOCK_SIZE - 1)) begin
							state <= S_IDLE;
						end
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	// read pipeline: store read stage, then the pipe-out write stage
	always_ff @(posedge okClk) begin
		if (dma_reset) begin
			mem_rvalid <= 1'b0;
			o_po_write <= 1'b0;
		end else begin
			mem_rvalid <= o_mem_re;
			o_po_write <= mem_rvalid;
		end
	end

	always_ff @(posedge okClk) begin
		if (mem_rvalid) begin
			o_po_data <= i_mem_rdata;
		end
	end

endmodule

// ==== dma/word_store.sv ====
`timescale 1ns/1ns

module word_store (
	input  logic                   okClk,
	input  logic                   i_reset,
	input  logic                   i_we,
	input  host_bridge_pkg::addr_t i_waddr,
	input  host_bridge_pkg::word_t i_wdata,
	input  logic                   i_re,
	input  host_bridge_pkg::addr_t i_raddr,
	output host_bridge_pkg::word_t o_rdata,
	output logic                   o_calib_done
);
	import host_bridge_pkg::*;

	word_t              mem [2**MEM_AW];
	logic [CALIB_W-1:0] calib_cnt;

	// ------------------------------------------------------------------------
	// memory array, write through the same edge, read one cycle later
	// ------------------------------------------------------------------------
	always_ff @(posedge okClk) begin
		if (i_we) begin
			mem[i_waddr] <= i_wdata;
		end
		if (i_re) begin
			o_rdata <= mem[i_raddr];
		end
	end

	// ------------------------------------------------------------------------
	// power-up calibration
	// ------------------------------------------------------------------------
	always_ff @(posedge okClk) begin
		if (i_reset) begin
			calib_cnt    <= '0;
			o_calib_done <= 1'b0;
		end else if (!o_calib_done) begin
			calib_cnt <= calib_cnt + 1'b1;
			if (calib_cnt == CALIB_W'(CALIB_CYCLES - 1)) begin
				o_calib_done <= 1'b1;                 // sticks until the next reset
			end
		end
	end

endmodule

// ==== src/host_bridge_top.sv ====
`timescale 1ns/1ns

module host_bridge_top (
	input  logic                   okClk,
	input  logic                   i_reset,
	input  host_bridge_pkg::word_t i_ctrl,
	input  host_bridge_pkg::addr_t i_start_addr,
	input  logic                   i_pi_write,
	input  host_bridge_pkg::word_t i_pi_data,
	output logic                   o_pi_ready,
	input  logic                   i_po_read,
	output host_bridge_pkg::word_t o_po_data,
	output logic                   o_po_ready,
	output logic [7:0]             o_led
);
	import host_bridge_pkg::*;

	// pipe-in path
	logic   pi_read;
	word_t  pi_data;
	logic   pi_valid;
	count_t pi_count;
	logic   pi_full;
	logic   pi_empty;
	// pipe-out path
	logic   po_write;
	word_t  po_wdata;
	count_t po_count;
	logic   po_full;
	logic   po_empty;
	// store port
	logic   mem_we;
	addr_t  mem_waddr;
	word_t  mem_wdata;
	logic   mem_re;
	addr_t  mem_raddr;
	word_t  mem_rdata;
	logic   calib_done;
	logic   dma_busy;

	// ------------------------------------------------------------------------
	// status LEDs, lit low
	// ------------------------------------------------------------------------
	assign o_led = ~{pi_full, pi_empty, po_full, po_empty,
		i_ctrl[CTRL_PIPE_WRITE], i_ctrl[CTRL_PIPE_READ], calib_done, dma_busy};

	pipe_endpoints endpoints_i (
		.okClk          (okClk),
		.i_reset        (i_reset),
		.i_flush        (i_ctrl[CTRL_FLUSH]),
		.i_pi_write     (i_pi_write),
		.i_pi_data      (i_pi_data),
		.o_pi_ready     (o_pi_ready),
		.i_po_read      (i_po_read),
		.o_po_data      (o_po_data),
		.i_dma_pi_read  (pi_read),
		.o_dma_pi_data  (pi_data),
		.o_dma_pi_valid (pi_valid),
		.o_pi_count     (pi_count),
		.i_dma_po_write (po_write),
		.i_dma_po_data  (po_wdata),
		.o_po_count     (po_count),
		.o_po_ready     (o_po_ready),
		.o_pi_full      (pi_full),
		.o_pi_empty     (pi_empty),
		.o_po_full      (po_full),
		.o_po_empty     (po_empty)
	);

	block_dma dma_i (
		.okClk        (okClk),
		.i_reset      (i_reset),
		.i_ctrl       (i_ctrl),                   // flush decoded inside
		.i_start_addr (i_start_addr),
		.i_calib_done (calib_done),
		.o_pi_read    (pi_read),
		.i_pi_data    (pi_data),
		.i_pi_valid   (pi_valid),
		.i_pi_count   (pi_count),
		.o_po_write   (po_write),
		.o_po_data    (po_wdata),
		.i_po_count   (po_count),
		.o_mem_we     (mem_we),
		.o_mem_waddr  (mem_waddr),
		.o_mem_wdata  (mem_wdata),
		.o_mem_re     (mem_re),
		.o_mem_raddr  (mem_raddr),
		.i_mem_rdata  (mem_rdata),
		.o_busy       (dma_busy)
	);

	word_store store_i (
		.okClk        (okClk),
		.i_reset      (i_reset),                  // flush leaves the store alone
		.i_we         (mem_we),
		.i_waddr      (mem_waddr),
		.i_wdata      (mem_wdata),
		.i_re         (mem_re),
		.i_raddr      (mem_raddr),
		.o_rdata      (mem_rdata),
		.o_calib_done (calib_done)
	);

endmodule

// ==== dv/host_bridge_tb.sv ====
`timescale 1ns/1ns

module host_bridge_tb;
	import host_bridge_pkg::*;

	localparam int   TOTAL_BLOCKS = 12;                 // blocks moved over all tests
	localparam int   CYCLE_LIMIT  = TOTAL_BLOCKS * BLOCK_SIZE * 4 + 2 * FIFO_DEPTH;
	localparam int   FILL_WORDS   = 1000;               // throttle test, below the depth
	localparam word_t CTRL_RD = word_t'(1) << CTRL_PIPE_READ;
	localparam word_t CTRL_WR = word_t'(1) << CTRL_PIPE_WRITE;
	localparam word_t CTRL_FL = word_t'(1) << CTRL_FLUSH;

	logic        okClk;
	logic        i_reset;
	word_t       i_ctrl;
	addr_t       i_start_addr;
	logic        i_pi_write;
	word_t       i_pi_data;
	logic        o_pi_ready;
	logic        i_po_read;
	word_t       o_po_data;
	logic        o_po_ready;
	logic [7:0]  o_led;

	logic [15:0] lfsr_state;
	word_t       model_store [2**MEM_AW];                // mirrors the word store
	word_t       exp_q [$];                            // words expected from pipe-out
	int          cycles;
	int          errors;
	// pipe-out count model for the throttle check
	logic        watch_po;
	int          po_cnt;
	int          po_prev;
	int          po_pend_w;
	int          po_pend_r;

	host_bridge_top dut_i (
		.okClk        (okClk),
		.i_reset      (i_reset),
		.i_ctrl       (i_ctrl),
		.i_start_addr (i_start_addr),
		.i_pi_write   (i_pi_write),
		.i_pi_data    (i_pi_data),
		.o_pi_ready   (o_pi_ready),
		.i_po_read    (i_po_read),
		.o_po_data    (o_po_data),
		.o_po_ready   (o_po_ready),
		.o_led        (o_led)
	);

	initial begin
		okClk = 1'b0;
		forever #20 okClk = ~okClk;                    // 40 ns period
	end

	// ------------------------------------------------------------------------
	// helpers
	// ------------------------------------------------------------------------
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	task automatic rand_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int k = 0; k < n; k++) begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[30:0], lfsr_state[0]};          // one step per bit
		end
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			errors++;
			$display("Error: %s is %h, expected %h", name, got, exp);
			$display("Test FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic set_ctrl(input word_t ctrl, input addr_t addr);
		@(posedge okClk);
		i_ctrl       <= ctrl;
		i_start_addr <= addr;
	endtask

	task automatic wait_pi_ready;
		do @(negedge okClk); while (o_pi_ready !== 1'b1);
	endtask

	task automatic wait_po_ready;
		do @(negedge okClk); while (o_po_ready !== 1'b1);
	endtask

	task automatic wait_idle;
		do @(negedge okClk); while (o_led[0] !== 1'b1);  // busy lamp off
	endtask

	task automatic wait_drained;
		do @(negedge okClk); while (!(o_led[6] === 1'b0 && o_led[0] === 1'b1));
	endtask

	task automatic send_block(input logic to_store, inout addr_t waddr);
		logic [31:0] d;
		logic [31:0] gap;
		wait_pi_ready();
		for (int i = 0; i < BLOCK_SIZE; i++) begin
			rand_bits(32, d);
			@(posedge okClk);
			i_pi_write <= 1'b1;
			i_pi_data  <= d;
			exp_q.push_back(d);
			if (to_store) begin
				model_store[waddr] = d;
				waddr = waddr + 1'b1;              // store wraps like the DMA pointer
			end
		end
		@(posedge okClk);
		i_pi_write <= 1'b0;
		rand_bits(3, gap);
		repeat (gap) @(posedge okClk);
	endtask

	task automatic read_block;
		word_t exp;
		wait_po_ready();
		for (int i = 0; i < BLOCK_SIZE; i++) begin
			exp = exp_q.pop_front();
			@(posedge okClk);
			i_po_read <= 1'b1;
			@(posedge okClk);
			i_po_read <= 1'b0;
			@(negedge okClk);
			check_value("o_po_data", o_po_data, exp);
		end
	endtask

	task automatic queue_from_store(input addr_t a);
		exp_q.delete();
		for (int i = 0; i < BLOCK_SIZE; i++) begin
			exp_q.push_back(model_store[a]);
			a = a + 1'b1;
		end
	endtask

	task automatic clear_and_flush;
		set_ctrl('0, i_start_addr);
		wait_idle();
		set_ctrl(CTRL_FL, i_start_addr);
		set_ctrl('0, i_start_addr);
		repeat (3) @(posedge okClk);
	endtask

	// ------------------------------------------------------------------------
	// timeout and pipe-out throttle monitor
	// ------------------------------------------------------------------------
	always @(posedge okClk) begin
		cycles++;
		if (cycles > CYCLE_LIMIT) begin
			$display("run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Test FAILED");
			$fatal(1, "timeout");
		end
	end

	always @(negedge okClk) begin
		if (watch_po) begin
			po_prev = po_cnt;
			po_cnt  = po_cnt + po_pend_w - po_pend_r;  // count after the last edge
			check_value("o_po_ready", o_po_ready, po_prev >= BLOCK_SIZE);
			po_pend_w = dut_i.po_write;
			po_pend_r = i_po_read;
		end
	end

	// ------------------------------------------------------------------------
	// test sequence
	// ------------------------------------------------------------------------
	initial begin
		logic [31:0] r;
		logic [31:0] r2;
		addr_t       base;
		addr_t       waddr;
		addr_t       addr_a;
		addr_t       addr_b;
		int          pi_model;
		int          pi_prev;
		logic        exp_ready;
		lfsr_state   = 16'd13547;
		errors       = 0;
		cycles       = 0;
		watch_po     = 1'b0;
		po_cnt       = 0;
		po_pend_w    = 0;
		po_pend_r    = 0;
		i_reset      = 1'b1;
		i_ctrl       = '0;
		i_start_addr = '0;
		i_pi_write   = 1'b0;
		i_pi_data    = '0;
		i_po_read    = 1'b0;
		for (int i = 0; i < 2**MEM_AW; i++) begin
			model_store[i] = '0;
		end
		repeat (5) @(posedge okClk);
		i_reset <= 1'b0;

		// reset state, then calibration done
		@(negedge okClk);
		check_value("o_pi_ready", o_pi_ready, 1'b1);
		check_value("o_po_ready", o_po_ready, 1'b0);
		check_value("o_led", o_led, 8'hAF);
		repeat (CALIB_CYCLES + 2) @(negedge okClk);
		check_value("o_led", o_led, 8'hAD);

		// loopback of four blocks, with the pipe-out throttle watched
		rand_bits(MEM_AW, r);
		base  = addr_t'(r);
		waddr = base;
		exp_q.delete();
		set_ctrl(CTRL_WR, base);
		repeat (4) send_block(1'b1, waddr);
		wait_drained();
		set_ctrl(CTRL_RD, base);
		po_cnt    = 0;
		po_pend_w = 0;
		po_pend_r = 0;
		watch_po  = 1'b1;
		repeat (4) read_block();
		watch_po = 1'b0;
		clear_and_flush();

		// two blocks at block-aligned addresses, read back the second
		rand_bits(3, r);
		rand_bits(3, r2);
		addr_a = addr_t'(r[2:0] * BLOCK_SIZE);
		addr_b = addr_t'(((r[2:0] + 1 + r2 % 7) % 8) * BLOCK_SIZE);
		waddr  = addr_a;
		set_ctrl(CTRL_WR, addr_a);
		send_block(1'b1, waddr);
		wait_drained();
		set_ctrl('0, addr_a);
		waddr = addr_b;
		set_ctrl(CTRL_WR, addr_b);
		send_block(1'b1, waddr);
		wait_drained();
		set_ctrl('0, addr_b);
		queue_from_store(addr_b);
		set_ctrl(CTRL_RD, addr_b);
		read_block();
		clear_and_flush();

		// pipe-in throttle with the DMA off
		pi_model = 0;
		pi_prev  = 0;
		while (pi_model < FILL_WORDS) begin
			rand_bits(3, r);
			@(posedge okClk);
			exp_ready = (pi_prev <= PIPE_IN_LIMIT);
			pi_prev   = pi_model;
			if (r[2:0] != 3'd0) begin
				i_pi_write <= 1'b1;
				i_pi_data  <= word_t'(pi_model);
				pi_model++;
			end else begin
				i_pi_write <= 1'b0;
			end
			@(negedge okClk);
			check_value("o_pi_ready", o_pi_ready, exp_ready);
		end
		@(posedge okClk);
		i_pi_write <= 1'b0;
		clear_and_flush();

		// flush with both FIFOs partly filled
		for (int i = 0; i < 40; i++) begin
			@(posedge okClk);
			i_pi_write <= 1'b1;
			i_pi_data  <= word_t'(i);
		end
		@(posedge okClk);
		i_pi_write <= 1'b0;
		set_ctrl(CTRL_RD, base);
		wait_po_ready();
		set_ctrl(CTRL_FL, base);
		set_ctrl('0, base);
		repeat (2) @(negedge okClk);
		check_value("o_led[6]", o_led[6], 1'b0);
		check_value("o_led[4]", o_led[4], 1'b0);
		check_value("o_po_ready", o_po_ready, 1'b0);
		queue_from_store(addr_b);
		set_ctrl(CTRL_RD, addr_b);
		read_block();
		clear_and_flush();

		if (errors == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

// ==== dv/host_bridge_assert.sv ====
`timescale 1ns/1ns

module host_bridge_assert (
	input logic                    okClk,
	input logic                    i_reset,
	input logic                    i_write,
	input logic                    i_full,
	input host_bridge_pkg::count_t i_count,
	input logic                    i_mem_re,
	input logic                    i_calib_done
);
	import host_bridge_pkg::*;

	// throttles keep writers off a full FIFO
	assert property (@(posedge okClk) disable iff (i_reset)
		!(i_write && i_full))
		else $error("write strobe into a full FIFO");

	// store reads wait for calibration
	assert property (@(posedge okClk) disable iff (i_reset)
		i_mem_re |-> i_calib_done)
		else $error("read burst before calibration done");

	// a full count holds or steps down and never wraps past the depth
	assert property (@(posedge okClk) disable iff (i_reset)
		(i_count == count_t'(FIFO_DEPTH)) |=> (i_count >= count_t'(FIFO_DEPTH - 1)))
		else $error("FIFO count wrapped past depth");

endmodule

bind word_fifo host_bridge_assert fifo_assert_i (
	.okClk        (okClk),
	.i_reset      (i_reset),
	.i_write      (i_write),
	.i_full       (o_full),
	.i_count      (o_count),
	.i_mem_re     (1'b0),
	.i_calib_done (1'b1)
);

bind block_dma host_bridge_assert dma_assert_i (
	.okClk        (okClk),
	.i_reset      (i_reset),
	.i_write      (1'b0),
	.i_full       (1'b0),
	.i_count      ('0),
	.i_mem_re     (o_mem_re),
	.i_calib_done (i_calib_done)
);

// ==== filelist.f ====
common/host_bridge_pkg.sv
src/word_fifo.sv
pipe/pipe_endpoints.sv
dma/block_dma.sv
dma/word_store.sv
src/host_bridge_top.sv
dv/host_bridge_tb.sv
dv/host_bridge_assert.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the host bridge testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module host_bridge_tb -f filelist.f -o sim_host_bridge

output=$(./obj_dir/sim_host_bridge 2>&1) || true
echo "$output"

if echo "$output" | grep -q "^Test OK$"; then
	exit 0
else
	exit 1
fi
